/* sim.f */
+incdir+include
design/dram_addr_pkg.sv
design/dram_cmd_pkg.sv
design/request_queue.sv
design/bank_tracker.sv
design/refresh_timer.sv
design/cmd_arbiter.sv
design/dram_scheduler.sv
verification/tb_dram_scheduler.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; the exit status follows the testbench result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_dram_scheduler -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Done: no errors" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verification/tb_dram_scheduler.sv */
// self-checking testbench with an ideal DRAM side; the run spans two refresh intervals
`default_nettype none
`include "dram_config.svh"

module tb_dram_scheduler import dram_addr_pkg::*, dram_cmd_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS      = 5;
	localparam int TIMEOUT_CYCLES = 4 * (`DRAM_T_REFI + `DRAM_T_RFC) * NUM_TESTS;
	localparam int NUM_BANKS      = `DRAM_NUM_BANKS;

	logic      clk;
	logic      rst_n;
	logic      req_valid;
	mem_req_t  req;
	logic      queue_full;
	logic      cmd_valid;
	dram_cmd_t cmd;

	// reference model of the rank, built from the observed command stream
	logic        open_m   [NUM_BANKS];
	row_t        row_m    [NUM_BANKS];
	int          last_act [NUM_BANKS];
	int          last_pre [NUM_BANKS];
	int          last_act_any;
	bank_group_t last_act_bg;
	int          last_col;
	bank_group_t last_col_bg;
	logic        last_col_wr;
	int          last_ref;

	mem_req_t    exp_q[$];    // accepted requests not yet finished
	dram_cmd_t   cmd_log[$];  // non-refresh strobes of the current test
	int          cycle = 0;
	int          ref_count = 0;
	int          prea_count = 0;
	int          error_count = 0;
	int unsigned rand_state = 37;
	string       test_name = "reset";

	dram_scheduler DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.queue_full (queue_full),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_failure(string what);
		error_count++;
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			report_failure($sformatf("timeout: the run did not finish in %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state;
	endfunction

	function automatic timer_t cycles_between(int from, int to);
		int d;
		d = to - from;
		return (d >= (1 << `DRAM_TIMER_WIDTH)) ? '1 : timer_t'(d);  // saturates like the DUT counters
	endfunction

	function automatic mem_req_t make_req(logic write, bank_group_t bg, bank_t bank, row_t row,
			column_t col);
		mem_req_t r;
		r.write           = write;
		r.addr.bank_group = bg;
		r.addr.bank       = bank;
		r.addr.row        = row;
		r.addr.column     = col;
		return r;
	endfunction

	function automatic mem_req_t random_req();
		logic [31:0] v;
		v = next_random();
		// few rows, many hits
		return make_req(v[16], v[18:17], v[20:19], row_t'(v[22:21]), v[30:23]);
	endfunction

	function automatic dram_cmd_t make_cmd(dram_cmd_e kind, mem_req_t r);
		dram_cmd_t c;
		c.cmd        = kind;
		c.bank_group = r.addr.bank_group;
		c.bank       = r.addr.bank;
		c.row        = r.addr.row;
		c.column     = r.addr.column;
		return c;
	endfunction

	// blank the fields a command type does not use
	function automatic dram_cmd_t visible_fields(dram_cmd_t c);
		dram_cmd_t v;
		v = c;
		if (c.cmd != ACT) begin
			v.row = '0;
		end
		if (c.cmd != RD && c.cmd != WR) begin
			v.column = '0;
		end
		if (c.cmd == PREA || c.cmd == REF) begin
			v.bank_group = '0;
			v.bank       = '0;
		end
		return v;
	endfunction

	function automatic string cmd_text(dram_cmd_t c);
		return $sformatf("%s bg %0d bank %0d row 0x%h col 0x%h", c.cmd.name(), c.bank_group, c.bank,
			c.row, c.column);
	endfunction

	function automatic logic any_open();
		logic found;
		found = 1'b0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			found = found | open_m[i];
		end
		return found;
	endfunction

	// in-order service: hit gives RD/WR, closed bank ACT, other row PRE
	function automatic dram_cmd_t next_expected(mem_req_t r);
		bank_id_t b;
		b = {r.addr.bank_group, r.addr.bank};
		if (open_m[b] && row_m[b] == r.addr.row) begin
			if (r.write) begin
				return make_cmd(WR, r);
			end
			return make_cmd(RD, r);
		end
		if (open_m[b]) begin
			return make_cmd(PRE, r);
		end
		return make_cmd(ACT, r);
	endfunction

	task automatic check_cmd(string name, dram_cmd_t expected, dram_cmd_t actual);
		if (visible_fields(actual) !== visible_fields(expected)) begin
			report_failure($sformatf("mismatch %s: expected %s, actual %s", name,
				cmd_text(expected), cmd_text(actual)));
		end
	endtask

	task automatic check_flag(string name, logic expected, logic actual);
		if (actual !== expected) begin
			report_failure($sformatf("mismatch %s %s: expected %b, actual %b", test_name, name,
				expected, actual));
		end
	endtask

	task automatic check_gap(string name, timer_t min_gap, timer_t actual);
		if (actual < min_gap) begin
			report_failure($sformatf(
				"mismatch %s: expected a gap of at least %0d cycles, actual %0d",
				name, min_gap, actual));
		end
	endtask

	task automatic check_strobe(dram_cmd_t c, int now);
		bank_id_t b;
		string    t;
		b = {c.bank_group, c.bank};
		t = test_name;
		check_gap({t, " tRFC"}, timer_t'(`DRAM_T_RFC), cycles_between(last_ref, now));
		case (c.cmd)
			PREA: begin
				if (!any_open()) begin
					report_failure($sformatf("%s: PREA issued while every bank was closed", t));
				end
				for (int i = 0; i < NUM_BANKS; i++) begin
					if (open_m[i]) begin
						check_gap({t, " tRAS"}, timer_t'(`DRAM_T_RAS),
							cycles_between(last_act[i], now));
						last_pre[i] = now;
					end
					open_m[i] = 1'b0;
				end
				prea_count++;
			end
			REF: begin
				if (any_open()) begin
					report_failure($sformatf("%s: REF issued while a bank was still open", t));
				end
				for (int i = 0; i < NUM_BANKS; i++) begin
					check_gap({t, " tRP"}, timer_t'(`DRAM_T_RP), cycles_between(last_pre[i], now));
				end
				check_gap({t, " tREFI"}, timer_t'(`DRAM_T_REFI + `DRAM_T_RFC),
					cycles_between(last_ref, now));
				last_ref = now;
				ref_count++;
			end
			default: begin
				if (exp_q.size() == 0) begin
					report_failure($sformatf("%s: command strobe with no request pending", t));
				end
				check_cmd(t, next_expected(exp_q[0]), c);
				cmd_log.push_back(c);
				case (c.cmd)
					ACT: begin
						check_gap({t, " tRC"}, timer_t'(`DRAM_T_RC),
							cycles_between(last_act[b], now));
						check_gap({t, " tRP"}, timer_t'(`DRAM_T_RP),
							cycles_between(last_pre[b], now));
						check_gap({t, " tRRD"}, (c.bank_group == last_act_bg) ?
							timer_t'(`DRAM_T_RRD_L) : timer_t'(`DRAM_T_RRD_S),
							cycles_between(last_act_any, now));
						open_m[b]    = 1'b1;
						row_m[b]     = c.row;
						last_act[b]  = now;
						last_act_any = now;
						last_act_bg  = c.bank_group;
					end
					PRE: begin
						check_gap({t, " tRAS"}, timer_t'(`DRAM_T_RAS),
							cycles_between(last_act[b], now));
						open_m[b]   = 1'b0;
						last_pre[b] = now;
					end
					default: begin  // RD or WR ends the request
						check_gap({t, " tRCD"}, timer_t'(`DRAM_T_RCD),
							cycles_between(last_act[b], now));
						check_gap({t, " tCCD"}, (c.bank_group == last_col_bg) ?
							timer_t'(`DRAM_T_CCD_L) : timer_t'(`DRAM_T_CCD_S),
							cycles_between(last_col, now));
						if (last_col_wr && c.cmd == RD) begin
							check_gap({t, " tWTR"}, (c.bank_group == last_col_bg) ?
								timer_t'(`DRAM_T_WTR_L) : timer_t'(`DRAM_T_WTR_S),
								cycles_between(last_col, now));
						end
						last_col    = now;
						last_col_bg = c.bank_group;
						last_col_wr = (c.cmd == WR);
						void'(exp_q.pop_front());
					end
				endcase
			end
		endcase
	endtask

	// cmd is registered, so it is settled at the falling edge
	always @(negedge clk) begin
		if (rst_n && cmd_valid) begin
			check_strobe(cmd, cycle);
		end
	end

	task automatic push_req(mem_req_t r);
		while (queue_full) @(negedge clk);
		req_valid = 1'b1;
		req       = r;
		exp_q.push_back(r);
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0) @(negedge clk);
	endtask

	task automatic wait_refresh();
		int n;
		n = ref_count;
		while (ref_count == n) @(negedge clk);
	endtask

	task automatic start_test(string name);
		wait_idle();
		test_name = name;
		cmd_log.delete();
	endtask

	task automatic check_logged(int idx, dram_cmd_e kind, mem_req_t r);
		if (idx >= cmd_log.size()) begin
			report_failure($sformatf("%s: command %0d of the test was never issued",
				test_name, idx));
		end
		check_cmd($sformatf("%s command %0d", test_name, idx), make_cmd(kind, r), cmd_log[idx]);
	endtask

	task automatic check_log_length(int n);
		if (cmd_log.size() != n) begin
			report_failure($sformatf("mismatch %s: expected %0d commands, actual %0d",
				test_name, n, cmd_log.size()));
		end
	endtask

	// every request ends with exactly one RD or WR
	task automatic check_served_count(int n);
		int served;
		served = 0;
		foreach (cmd_log[i]) begin
			if (cmd_log[i].cmd == RD || cmd_log[i].cmd == WR) begin
				served++;
			end
		end
		if (served != n) begin
			report_failure($sformatf("mismatch %s: expected %0d requests served, actual %0d",
				test_name, n, served));
		end
	endtask

	task automatic test_row_hits();
		mem_req_t r0;
		mem_req_t r1;
		mem_req_t r2;
		start_test("row hits");
		r0 = make_req(1'b0, 2'd0, 2'd1, 12'h123, 8'h10);
		r1 = make_req(1'b0, 2'd0, 2'd1, 12'h123, 8'h20);
		r2 = make_req(1'b1, 2'd0, 2'd1, 12'h123, 8'h30);
		push_req(r0);
		push_req(r1);
		push_req(r2);
		wait_idle();
		check_logged(0, ACT, r0);
		check_logged(1, RD, r0);
		check_logged(2, RD, r1);
		check_logged(3, WR, r2);
		check_log_length(4);
	endtask

	task automatic test_row_miss();
		mem_req_t miss;
		mem_req_t fresh;
		start_test("row miss");
		miss  = make_req(1'b0, 2'd0, 2'd1, 12'h2a5, 8'h44);  // bank still open on row 0x123
		fresh = make_req(1'b1, 2'd3, 2'd0, 12'h0f0, 8'h08);
		push_req(miss);
		push_req(fresh);
		wait_idle();
		check_logged(0, PRE, miss);
		check_logged(1, ACT, miss);
		check_logged(2, RD, miss);
		check_logged(3, ACT, fresh);
		check_logged(4, WR, fresh);
		check_log_length(5);
	endtask

	task automatic test_queue_full();
		start_test("queue full");
		wait_refresh();  // nothing is served during tRFC
		for (int n = 0; n < `DRAM_QUEUE_DEPTH; n++) begin
			push_req(random_req());
		end
		check_flag("queue_full after filling", 1'b1, queue_full);
		req_valid = 1'b1;  // dropped, never enters the model
		req       = random_req();
		@(negedge clk);
		req_valid = 1'b0;
		wait_idle();
		check_served_count(`DRAM_QUEUE_DEPTH);
		check_flag("queue_full after draining", 1'b0, queue_full);
	endtask

	task automatic test_spacing();
		start_test("spacing");
		for (int n = 0; n < 32; n++) begin
			push_req(random_req());
		end
		wait_idle();
	endtask

	task automatic test_refresh();
		mem_req_t r;
		int       old_prea;
		start_test("refresh");
		r = make_req(1'b0, 2'd2, 2'd3, 12'h3c3, 8'h5a);
		push_req(r);
		wait_idle();
		old_prea = prea_count;
		wait_refresh();
		check_flag("PREA before REF", 1'b1, prea_count != old_prea);
		cmd_log.delete();
		push_req(r);
		wait_idle();
		check_logged(0, ACT, r);  // PREA closed the bank
		check_logged(1, RD, r);
		check_log_length(2);
	endtask

	initial begin
		rst_n        = 1'b0;
		req_valid    = 1'b0;
		req          = '0;
		open_m       = '{default: 1'b0};
		last_act     = '{default: -1000};
		last_pre     = '{default: -1000};
		last_act_any = -1000;
		last_act_bg  = '0;
		last_col     = -1000;
		last_col_bg  = '0;
		last_col_wr  = 1'b0;
		last_ref     = -`DRAM_T_RFC;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_flag("queue_full", 1'b0, queue_full);
		check_flag("cmd_valid", 1'b0, cmd_valid);
		test_row_hits();
		test_row_miss();
		test_queue_full();
		test_spacing();
		test_refresh();
		if (error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			report_failure("errors were counted during the run");
		end
	end

endmodule

`default_nettype wire

/* design/dram_scheduler.sv */
// DRAM command scheduler for one rank; no output back-pressure, the source must watch queue_full
`default_nettype none

module dram_scheduler import dram_addr_pkg::*, dram_cmd_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      req_valid,
	input  mem_req_t  req,
	output logic      queue_full,
	output logic      cmd_valid,
	output dram_cmd_t cmd
);

	logic             head_valid;
	mem_req_t         head;
	logic             pop;
	bank_status_vec_t bank_status;
	logic             refresh_due;
	logic             refresh_busy;

	request_queue u_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.pop        (pop),
		.queue_full (queue_full),
		.head_valid (head_valid),
		.head       (head)
	);

	// tracker and refresh timer follow the issued stream
	bank_tracker u_banks (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.bank_status (bank_status)
	);

	refresh_timer u_refresh (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.refresh_due  (refresh_due),
		.refresh_busy (refresh_busy)
	);

	cmd_arbiter u_arbiter (
		.clk          (clk),
		.rst_n        (rst_n),
		.head_valid   (head_valid),
		.head         (head),
		.bank_status  (bank_status),
		.refresh_due  (refresh_due),
		.refresh_busy (refresh_busy),
		.pop          (pop),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd)
	);

endmodule

`default_nettype wire

/* design/cmd_arbiter.sv */
// in-order, one command at most every other cycle; a request cut by refresh restarts with ACT
`default_nettype none
`include "dram_config.svh"

module cmd_arbiter import dram_addr_pkg::*, dram_cmd_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             head_valid,
	input  mem_req_t         head,
	input  bank_status_vec_t bank_status,
	input  logic             refresh_due,
	input  logic             refresh_busy,
	output logic             pop,
	output logic             cmd_valid,
	output dram_cmd_t        cmd
);

	localparam timer_t CCD_L = timer_t'(`DRAM_T_CCD_L);
	localparam timer_t CCD_S = timer_t'(`DRAM_T_CCD_S);
	localparam timer_t RRD_L = timer_t'(`DRAM_T_RRD_L);
	localparam timer_t RRD_S = timer_t'(`DRAM_T_RRD_S);
	localparam timer_t WTR_L = timer_t'(`DRAM_T_WTR_L);
	localparam timer_t WTR_S = timer_t'(`DRAM_T_WTR_S);

	arb_state_e   state;
	arb_state_e   next_state;
	dram_cmd_t    next_cmd;
	logic         issue;
	bank_status_t head_st;
	logic         row_hit;
	logic         any_open;
	logic         all_pre_ok;
	logic         all_act_ok;
	timer_t       col_cnt;  // cycles since the last RD/WR strobe, saturating
	timer_t       act_cnt;  // same for ACT
	timer_t       col_need;
	timer_t       act_need;
	logic         last_col_wr;
	bank_group_t  last_col_bg;
	bank_group_t  last_act_bg;

	assign head_st = bank_status[{head.addr.bank_group, head.addr.bank}];
	assign row_hit = head_st.open && (head_st.row == head.addr.row);

	always_comb begin
		any_open   = 1'b0;
		all_pre_ok = 1'b1;
		all_act_ok = 1'b1;
		for (int i = 0; i < `DRAM_NUM_BANKS; i++) begin
			any_open   = any_open | bank_status[i].open;
			all_pre_ok = all_pre_ok & (!bank_status[i].open | bank_status[i].pre_ok);
			all_act_ok = all_act_ok & bank_status[i].act_ok;
		end
	end

	always_comb begin
		if (last_col_wr && !head.write) begin  // write to read turnaround
			col_need = (head.addr.bank_group == last_col_bg) ? WTR_L : WTR_S;
		end else begin
			col_need = (head.addr.bank_group == last_col_bg) ? CCD_L : CCD_S;
		end
		act_need = (head.addr.bank_group == last_act_bg) ? RRD_L : RRD_S;
	end

	// bank status lags the strobe by one cycle, so nothing is decided while cmd_valid is high
	always_comb begin
		next_state = state;
		issue      = 1'b0;
		pop        = 1'b0;
		next_cmd   = '0;
		next_cmd.cmd = NOP;
		if (!cmd_valid) begin
			case (state)
				SERVE: begin
					next_cmd.bank_group = head.addr.bank_group;
					next_cmd.bank       = head.addr.bank;
					next_cmd.row        = head.addr.row;
					next_cmd.column     = head.addr.column;
					if (refresh_due) begin
						next_state = REF_PRECHARGE;
					end else if (head_valid && !refresh_busy) begin
						if (row_hit) begin
							if (head_st.col_ok && col_cnt >= col_need) begin
								issue        = 1'b1;
								pop          = 1'b1;  // the column command ends the request
								next_cmd.cmd = head.write ? WR : RD;
							end
						end else if (head_st.open) begin
							issue        = head_st.pre_ok;
							next_cmd.cmd = PRE;
						end else begin
							issue        = head_st.act_ok && (act_cnt >= act_need);
							next_cmd.cmd = ACT;
						end
					end
				end
				REF_PRECHARGE: begin
					if (!any_open) begin
						next_state = REF_WAIT;
					end else if (all_pre_ok) begin
						issue        = 1'b1;
						next_cmd.cmd = PREA;
						next_state   = REF_WAIT;
					end
				end
				REF_WAIT: begin
					if (all_act_ok) begin
						issue        = 1'b1;
						next_cmd.cmd = REF;
						next_state   = SERVE;
					end
				end
				default: next_state = SERVE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= SERVE;
			cmd_valid   <= 1'b0;
			col_cnt     <= '1;
			act_cnt     <= '1;
			last_col_wr <= 1'b0;
			last_col_bg <= '0;
			last_act_bg <= '0;
		end else begin
			state     <= next_state;
			cmd_valid <= issue;
			if (col_cnt != '1) begin
				col_cnt <= col_cnt + 1'b1;
			end
			if (act_cnt != '1) begin
				act_cnt <= act_cnt + 1'b1;
			end
			if (pop) begin
				col_cnt     <= timer_t'(1);  // reads 1 in the strobe cycle
				last_col_wr <= (next_cmd.cmd == WR);
				last_col_bg <= next_cmd.bank_group;
			end
			if (issue && next_cmd.cmd == ACT) begin
				act_cnt     <= timer_t'(1);
				last_act_bg <= next_cmd.bank_group;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			cmd <= next_cmd;
		end
	end

	a_no_nop_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |-> cmd.cmd != NOP)
		else $error("command strobe carries NOP");

endmodule

`default_nettype wire

/* design/refresh_timer.sv */
// one refresh per T_REFI; the interval restarts only when the tRFC window of the last REF closes
`default_nettype none
`include "dram_config.svh"

module refresh_timer import dram_addr_pkg::*, dram_cmd_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cmd_valid,
	input  dram_cmd_t cmd,
	output logic      refresh_due,
	output logic      refresh_busy
);

	localparam timer_t REFI = timer_t'(`DRAM_T_REFI);
	localparam timer_t RFC  = timer_t'(`DRAM_T_RFC);

	timer_t refi_cnt;
	timer_t rfc_cnt;
	logic   ref_issued;

	assign ref_issued   = cmd_valid && (cmd.cmd == REF);
	assign refresh_busy = (rfc_cnt != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refi_cnt    <= REFI;
			rfc_cnt     <= '0;
			refresh_due <= 1'b0;
		end else if (ref_issued) begin
			refresh_due <= 1'b0;
			rfc_cnt     <= RFC;
		end else if (refresh_busy) begin
			rfc_cnt <= rfc_cnt - 1'b1;
			if (rfc_cnt == timer_t'(1)) begin
				refi_cnt <= REFI;  // window closes, next interval starts
			end
		end else if (!refresh_due) begin
			refi_cnt <= refi_cnt - 1'b1;
			if (refi_cnt == timer_t'(1)) begin
				refresh_due <= 1'b1;
			end
		end
	end

	a_ref_when_due: assert property (@(posedge clk) disable iff (!rst_n)
		ref_issued |-> refresh_due)
		else $error("REF issued with no refresh pending");

endmodule

`default_nettype wire

/* design/bank_tracker.sv */
// per-bank open rows and bank-local timers; follows the issued command stream only, no DRAM feedback
`default_nettype none
`include "dram_config.svh"

module bank_tracker import dram_addr_pkg::*, dram_cmd_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             cmd_valid,
	input  dram_cmd_t        cmd,
	output bank_status_vec_t bank_status
);

	localparam int NUM_BANKS = `DRAM_NUM_BANKS;

	// two short of the spacing; one edge loads, one edge registers the next command
	localparam timer_t LD_RCD = timer_t'(`DRAM_T_RCD - 2);
	localparam timer_t LD_RP  = timer_t'(`DRAM_T_RP - 2);
	localparam timer_t LD_RAS = timer_t'(`DRAM_T_RAS - 2);
	localparam timer_t LD_RC  = timer_t'(`DRAM_T_RC - 2);

	logic [NUM_BANKS-1:0] open_q;
	row_t                 row_q  [NUM_BANKS];
	timer_t               ras_q  [NUM_BANKS];
	timer_t               rc_q   [NUM_BANKS];
	timer_t               busy_q [NUM_BANKS];  // tRCD or tRP, whichever came last
	bank_id_t             cmd_bank;

	assign cmd_bank = {cmd.bank_group, cmd.bank};

	function automatic timer_t count_down(timer_t value);
		return (value == '0) ? value : value - 1'b1;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			open_q <= '0;
			ras_q  <= '{default: '0};
			rc_q   <= '{default: '0};
			busy_q <= '{default: '0};
		end else begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				ras_q[i]  <= count_down(ras_q[i]);
				rc_q[i]   <= count_down(rc_q[i]);
				busy_q[i] <= count_down(busy_q[i]);
				if (cmd_valid && cmd.cmd == PREA) begin
					open_q[i] <= 1'b0;
					busy_q[i] <= LD_RP;
				end else if (cmd_valid && cmd_bank == bank_id_t'(i)) begin
					case (cmd.cmd)
						ACT: begin
							open_q[i] <= 1'b1;
							ras_q[i]  <= LD_RAS;
							rc_q[i]   <= LD_RC;
							busy_q[i] <= LD_RCD;
						end
						PRE: begin
							open_q[i] <= 1'b0;
							busy_q[i] <= LD_RP;
						end
						default: ;  // RD, WR leave bank-local state alone
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_BANKS; i++) begin
			if (cmd_valid && cmd.cmd == ACT && cmd_bank == bank_id_t'(i)) begin
				row_q[i] <= cmd.row;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_BANKS; i++) begin
			bank_status[i].open   = open_q[i];
			bank_status[i].row    = row_q[i];
			bank_status[i].pre_ok = (ras_q[i] == '0);
			bank_status[i].act_ok = !open_q[i] && (busy_q[i] == '0) && (rc_q[i] == '0);
			bank_status[i].col_ok = open_q[i] && (busy_q[i] == '0);
		end
	end

	// arbiter decisions checked against the state this module holds
	a_act_to_closed: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid && cmd.cmd == ACT |-> !open_q[cmd_bank])
		else $error("ACT issued to an open bank");

	a_col_to_open: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid && (cmd.cmd == RD || cmd.cmd == WR) |-> open_q[cmd_bank])
		else $error("RD or WR issued to a closed bank");

endmodule

`default_nettype wire

/* design/request_queue.sv */
// in-order request FIFO; a request strobed while full is dropped and a pop needs a valid head
`default_nettype none
`include "dram_config.svh"

module request_queue import dram_addr_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     req_valid,
	input  mem_req_t req,
	input  logic     pop,
	output logic     queue_full,
	output logic     head_valid,
	output mem_req_t head
);

	localparam int DEPTH = `DRAM_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	mem_req_t         mem_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             push;

	assign push       = req_valid && !queue_full;  // strobe is lost when full
	assign queue_full = (count_q == CNT_W'(DEPTH));
	assign head_valid = (count_q != '0);
	assign head       = mem_q[rd_ptr_q];

	// wraps for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (push) begin
			mem_q[wr_ptr_q] <= req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;  // idle, or push and pop together
			endcase
		end
	end

	// the arbiter only retires a request it has seen at the head
	a_pop_has_head: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> head_valid)
		else $error("request queue popped while empty");

endmodule

`default_nettype wire

/* design/dram_cmd_pkg.sv */
// command and bank status types; fields of a command that its type does not use carry no meaning
`default_nettype none
`include "dram_config.svh"

package dram_cmd_pkg;

	import dram_addr_pkg::*;

	typedef enum logic [2:0] {
		NOP,
		ACT,
		RD,
		WR,
		PRE,
		PREA,  // precharge all banks
		REF
	} dram_cmd_e;

	typedef struct packed {
		dram_cmd_e   cmd;
		bank_group_t bank_group;  // not for PREA or REF
		bank_t       bank;
		row_t        row;         // ACT only
		column_t     column;      // RD and WR only
	} dram_cmd_t;

	// view of one bank as seen by the arbiter
	typedef struct packed {
		logic open;
		row_t row;
		logic pre_ok;  // tRAS met
		logic act_ok;  // closed, tRP and tRC met
		logic col_ok;  // open and tRCD met
	} bank_status_t;

	typedef bank_status_t [`DRAM_NUM_BANKS-1:0] bank_status_vec_t;

	typedef enum logic [1:0] {
		SERVE,
		REF_PRECHARGE,
		REF_WAIT
	} arb_state_e;

endpackage

`default_nettype wire

/* design/dram_addr_pkg.sv */
// address layout is row, bank group, bank, column from the top bit down; no rank or channel field
`default_nettype none
`include "dram_config.svh"

package dram_addr_pkg;

	typedef logic [`DRAM_BG_WIDTH-1:0]   bank_group_t;
	typedef logic [`DRAM_BANK_WIDTH-1:0] bank_t;
	typedef logic [`DRAM_ROW_WIDTH-1:0]  row_t;
	typedef logic [`DRAM_COL_WIDTH-1:0]  column_t;

	// flat bank number, bank group in the upper bits
	typedef logic [`DRAM_BG_WIDTH+`DRAM_BANK_WIDTH-1:0] bank_id_t;

	typedef struct packed {
		row_t        row;
		bank_group_t bank_group;
		bank_t       bank;
		column_t     column;
	} dram_addr_t;

	typedef struct packed {
		logic       write;  // 0 for a read
		dram_addr_t addr;
	} mem_req_t;

	// every timing counter in the scheduler
	typedef logic [`DRAM_TIMER_WIDTH-1:0] timer_t;

endpackage

`default_nettype wire

/* include/dram_config.svh */
// timings are in controller clock cycles and must each be 2 or more; T_REFI must fit in the timer width
`ifndef DRAM_CONFIG_SVH
`define DRAM_CONFIG_SVH

// request queue
`define DRAM_QUEUE_DEPTH 8

// address fields, row is the most significant
`define DRAM_BG_WIDTH   2
`define DRAM_BANK_WIDTH 2
`define DRAM_ROW_WIDTH  12
`define DRAM_COL_WIDTH  8

// one rank holds every bank of every bank group
`define DRAM_NUM_BANKS (1 << (`DRAM_BG_WIDTH + `DRAM_BANK_WIDTH))

// bank-local timings
`define DRAM_T_RCD 4   // ACT to RD/WR
`define DRAM_T_RP  4   // PRE to ACT
`define DRAM_T_RAS 10  // ACT to PRE
`define DRAM_T_RC  14  // ACT to ACT, same bank

// rank-wide timings, _L within a bank group and _S across groups
`define DRAM_T_CCD_L 4
`define DRAM_T_CCD_S 2
`define DRAM_T_RRD_L 4
`define DRAM_T_RRD_S 2
`define DRAM_T_WTR_L 6
`define DRAM_T_WTR_S 3

// refresh
`define DRAM_T_REFI 400  // interval between refreshes
`define DRAM_T_RFC  20   // rank blocked after REF

// down and up counters, wide enough for T_REFI
`define DRAM_TIMER_WIDTH 9

`endif
